/* des_ofb_top.f */
src/des_pkg.sv
src/des_round.sv
src/des_key_schedule.sv
src/des_cipher.sv
src/ofb_stream.sv
src/des_ofb_top.sv
test/des_ofb_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= des_ofb_tb
FILELIST  ?= des_ofb_top.f
OBJDIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)

run: build
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* test/des_ofb_tb.sv */
`default_nettype none

module des_ofb_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import des_pkg::*;

  localparam int k_kat    = 0; // fixed known bytes only
  localparam int k_ref    = 1; // record as reference stream
  localparam int k_xor    = 2; // output xor follows input xor
  localparam int k_repeat = 3;
  localparam int k_hold   = 4; // sink withholds credits
  localparam int num_rows = 6;

  typedef struct packed {
    int          kind;
    int          n;
    logic [63:0] key;
    logic [63:0] iv;
    logic [63:0] ct;    // byte 0 in the top bits
    logic [63:0] exp;
    logic [7:0]  known; // bit i set when exp byte i is fixed
  } row_t;

  logic       CLK;
  logic       RST;
  ofb_cfg_t   cfg;
  logic       cfg_load;
  byte_beat_t in_beat;
  logic       out_credit;
  logic       in_credit;
  byte_beat_t out_beat;

  row_t        rows [num_rows];
  logic [7:0]  got [$];
  logic [7:0]  ref_out [8];
  logic [63:0] ref_ct;
  logic [63:0] cur_ct;
  int          cur_n;
  int          sent, src_credits, granted, accepted;
  int          owed, sink_delay;
  logic        hold;
  int          errors, tests_run, tests_failed;
  integer      seed;

  des_ofb_top des_ofb_top_inst (
    .CLK        (CLK),
    .RST        (RST),
    .cfg        (cfg),
    .cfg_load   (cfg_load),
    .in_beat    (in_beat),
    .out_credit (out_credit),
    .in_credit  (in_credit),
    .out_beat   (out_beat)
  );

  always #20 CLK = ~CLK;

  function automatic logic [7:0] byte_of(logic [63:0] w, int i);
    return w[63-8*i -: 8];
  endfunction

  function automatic string test_name(int kind);
    case (kind)
      k_kat:    return "known answer";
      k_ref:    return "reference stream";
      k_xor:    return "data independence";
      k_repeat: return "reload repeat";
      default:  return "credit hold";
    endcase
  endfunction

  // one clock: sample outputs after the edge, then drive source and sink
  task automatic step_cycle();
    @(posedge CLK);
    #2;
    if (out_beat.valid) begin
      got.push_back(out_beat.data);
      owed++;
    end
    if (in_credit) begin
      src_credits++;
      granted++;
      if (granted > accepted + 1) begin
        errors++;
        $display("error at %0t ns: %0d input credits granted for %0d accepted bytes",
                 $time, granted, accepted);
      end
    end
    in_beat = '{valid: 1'b0, data: 8'h00};
    if (src_credits > 0 && sent < cur_n) begin
      in_beat = '{valid: 1'b1, data: byte_of(cur_ct, sent)};
      sent++;
      src_credits--;
      accepted++;
    end
    out_credit = 1'b0;
    if (!hold && owed > 0) begin
      if (sink_delay == 0) begin
        out_credit = 1'b1;
        owed--;
        sink_delay = $random(seed) & 3;
      end else begin
        sink_delay--;
      end
    end
  endtask

  task automatic run_row(input int r);
    row_t       row;
    logic [7:0] b;
    int         errs_before;
    row = rows[r];
    errs_before = errors;
    if (row.kind == k_hold) begin
      while (owed > 0) step_cycle(); // all sink slots back before the stall
      repeat (4) step_cycle();
      hold = 1'b1;
    end
    got.delete();
    sent = 0;
    src_credits = 0;
    granted = 0;
    accepted = 0;
    cur_ct = row.ct;
    cur_n = row.n;
    cfg = '{key: row.key, iv: row.iv};
    cfg_load = 1'b1;
    step_cycle();
    cfg_load = 1'b0;
    if (row.kind == k_hold) begin
      while (got.size() < out_credits) step_cycle();
      repeat (80) step_cycle();
      if (got.size() != out_credits) begin
        errors++;
        $display("error at %0t ns: %0d bytes sent with credits withheld, expected %0d",
                 $time, got.size(), out_credits);
      end
      hold = 1'b0;
    end
    while (got.size() < cur_n) step_cycle();
    repeat (24) step_cycle(); // cipher idle and the last credit seen
    if (got.size() != cur_n) begin
      errors++;
      $display("error at %0t ns: row %0d produced %0d bytes for %0d sent",
               $time, r, got.size(), cur_n);
    end
    for (int i = 0; i < cur_n; i++) begin
      b = got[i];
      if (row.known[i] && b !== byte_of(row.exp, i)) begin
        errors++;
        $display("mismatch at %0t ns: row %0d byte %0d got %02h expected %02h",
                 $time, r, i, b, byte_of(row.exp, i));
      end
      if (row.kind == k_ref) ref_out[i] = b;
      if (row.kind == k_xor && (b ^ ref_out[i]) !== (byte_of(row.ct, i) ^ byte_of(ref_ct, i))) begin
        errors++;
        $display("mismatch at %0t ns: row %0d byte %0d xor %02h expected %02h", $time, r, i,
                 b ^ ref_out[i], byte_of(row.ct, i) ^ byte_of(ref_ct, i));
      end
      if ((row.kind == k_repeat || row.kind == k_hold) && b !== ref_out[i]) begin
        errors++;
        $display("mismatch at %0t ns: row %0d byte %0d got %02h expected %02h",
                 $time, r, i, b, ref_out[i]);
      end
    end
    if (row.kind == k_ref) ref_ct = row.ct;
    tests_run++;
    if (errors != errs_before) tests_failed++;
    $display("row %0d %s: %0d bytes, %s", r, test_name(row.kind), cur_n,
             (errors == errs_before) ? "ok" : "errors");
  endtask

  task automatic check_idle(input string phase);
    @(posedge CLK);
    #2;
    if (out_beat.valid || in_credit) begin
      errors++;
      $display("error at %0t ns: output active %s before cfg_load", $time, phase);
    end
  endtask

  initial begin
    CLK = 1'b0;
    RST = 1'b0;
    cfg = '0;
    cfg_load = 1'b0;
    in_beat = '{valid: 1'b0, data: 8'h00};
    out_credit = 1'b0;
    hold = 1'b0;
    seed = 56984;
    owed = 0;
    sink_delay = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    cur_n = 0;
    // key and iv of the standard DES example, E(iv) = 85e813540f0ab405
    rows[0] = '{kind: k_kat, n: 1, key: 64'h133457799BBCDFF1, iv: 64'h0123456789ABCDEF,
                ct: 64'h00 << 56, exp: 64'h85 << 56, known: 8'h01};
    rows[1] = '{kind: k_kat, n: 1, key: 64'h133457799BBCDFF1, iv: 64'h0123456789ABCDEF,
                ct: 64'hFF << 56, exp: 64'h7A << 56, known: 8'h01};
    rows[2] = '{kind: k_ref, n: 8, key: 64'h133457799BBCDFF1, iv: 64'h0123456789ABCDEF,
                ct: 64'h0011223344556677, exp: 64'h85 << 56, known: 8'h01};
    rows[3] = '{kind: k_xor, n: 8, key: 64'h133457799BBCDFF1, iv: 64'h0123456789ABCDEF,
                ct: 64'hA55A0FF03CC39669, exp: 64'h20 << 56, known: 8'h01};
    rows[4] = '{kind: k_repeat, n: 8, key: 64'h133457799BBCDFF1, iv: 64'h0123456789ABCDEF,
                ct: 64'h0011223344556677, exp: 64'h85 << 56, known: 8'h01};
    rows[5] = '{kind: k_hold, n: 8, key: 64'h133457799BBCDFF1, iv: 64'h0123456789ABCDEF,
                ct: 64'h0011223344556677, exp: 64'h85 << 56, known: 8'h01};

    repeat (2) check_idle("in reset");
    RST = 1'b1;
    repeat (4) check_idle("after reset");
    tests_run++;
    if (errors != 0) tests_failed++;
    $display("reset state: %s", (errors == 0) ? "ok" : "errors");

    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog sized from the table
  initial begin
    int total;
    int limit;
    #1;
    total = 0;
    for (int r = 0; r < num_rows; r++) begin
      total += rows[r].n;
    end
    limit = 400 * total;
    repeat (limit) @(posedge CLK);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* src/des_ofb_top.sv */
`default_nettype none

module des_ofb_top (
  input  logic                CLK,
  input  logic                RST,
  input  des_pkg::ofb_cfg_t   cfg,
  input  logic                cfg_load,
  input  des_pkg::byte_beat_t in_beat,
  input  logic                out_credit,
  output logic                in_credit,
  output des_pkg::byte_beat_t out_beat
);

  import des_pkg::*;

  des_block_u block;
  des_block_u result;
  logic       start;
  logic       done;

  ofb_stream ofb_stream_inst (
    .CLK        (CLK),
    .RST        (RST),
    .cfg_load   (cfg_load),
    .iv         (cfg.iv),
    .in_beat    (in_beat),
    .out_credit (out_credit),
    .done       (done),
    .result     (result),
    .in_credit  (in_credit),
    .out_beat   (out_beat),
    .start      (start),
    .block      (block)
  );

  des_cipher des_cipher_inst (
    .CLK    (CLK),
    .RST    (RST),
    .start  (start),
    .block  (block),
    .key    (cfg.key), // sampled by the key schedule on start
    .done   (done),
    .result (result)
  );

endmodule

`default_nettype wire

/* src/ofb_stream.sv */
`default_nettype none

module ofb_stream (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        cfg_load,
  input  logic [des_pkg::block_w-1:0] iv,
  input  des_pkg::byte_beat_t         in_beat,
  input  logic                        out_credit,
  input  logic                        done,
  input  des_pkg::des_block_u         result,
  output logic                        in_credit,
  output des_pkg::byte_beat_t         out_beat,
  output logic                        start,
  output des_pkg::des_block_u         block
);

  import des_pkg::*;

  des_block_u          fb_q;    // feedback register
  logic [byte_w-1:0]   ks_q;
  logic                ks_ready;
  logic [byte_w-1:0]   ct_q;    // one-byte ciphertext buffer
  logic                ct_valid;
  logic [credit_w-1:0] credit_q;
  logic [byte_w-1:0]   out_data_q;
  logic                out_valid_q;
  logic                start_q;
  logic                in_credit_q;
  logic                fire;

  assign fire = ks_ready && ct_valid && credit_q != '0;

  always_ff @(posedge CLK) begin
    if (cfg_load) begin
      fb_q.word <= iv;
    end else if (fire) begin
      fb_q.word <= {fb_q.word[block_w-byte_w-1:0], ks_q}; // keystream byte enters low end
    end
    if (done) ks_q <= result.word[block_w-1 -: byte_w];
    if (in_beat.valid) ct_q <= in_beat.data;
    if (fire) out_data_q <= ct_q ^ ks_q;
  end

  always_ff @(posedge CLK or negedge RST) begin
    if (!RST) begin
      start_q     <= 1'b0;
      in_credit_q <= 1'b0;
      out_valid_q <= 1'b0;
      ks_ready    <= 1'b0;
      ct_valid    <= 1'b0;
      credit_q    <= credit_w'(out_credits);
    end else begin
      start_q     <= cfg_load | fire;
      in_credit_q <= cfg_load | out_valid_q; // refill after the byte has left
      out_valid_q <= fire;

      if (cfg_load || fire) begin
        ks_ready <= 1'b0;
      end else if (done) begin
        ks_ready <= 1'b1;
      end

      if (cfg_load) begin
        ct_valid <= 1'b0;
      end else if (in_beat.valid) begin
        ct_valid <= 1'b1;
      end else if (fire) begin
        ct_valid <= 1'b0;
      end

      case ({fire, out_credit})
        2'b10:   credit_q <= credit_q - credit_w'(1);
        2'b01:   credit_q <= credit_q + credit_w'(1);
        default: credit_q <= credit_q;
      endcase
    end
  end

  assign start     = start_q;
  assign block     = fb_q;
  assign in_credit = in_credit_q;
  assign out_beat  = '{valid: out_valid_q, data: out_data_q};

  // sink cannot hand back a slot while all of them are here
  a_credit_bound: assert property (@(posedge CLK) disable iff (!RST)
    out_credit |-> credit_q != credit_w'(out_credits));

endmodule

`default_nettype wire

/* src/des_cipher.sv */
`default_nettype none

module des_cipher (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      start,
  input  des_pkg::des_block_u       block,
  input  logic [des_pkg::key_w-1:0] key,
  output logic                      done,
  output des_pkg::des_block_u       result
);

  import des_pkg::*;

  des_block_u          state_q;
  des_block_u          round_out;
  logic [block_w-1:0]  ip_word;
  logic [block_w-1:0]  preoutput;
  logic [block_w-1:0]  fp_word;
  logic [subkey_w-1:0] subkey;
  logic [round_w-1:0]  round_cnt;
  logic                busy;
  logic                last_round;

  des_key_schedule des_key_schedule_inst (
    .CLK    (CLK),
    .RST    (RST),
    .start  (start),
    .step   (busy),
    .key    (key),
    .subkey (subkey)
  );

  des_round des_round_inst (
    .half_in  (state_q),
    .subkey   (subkey),
    .half_out (round_out)
  );

  always_comb begin
    for (int i = 0; i < block_w; i++) begin
      ip_word[block_w-1-i] = block.word[block_w-1-ip_tab[i]];
    end
  end

  assign preoutput = {round_out.halves.right, round_out.halves.left}; // undo last swap

  always_comb begin
    for (int i = 0; i < block_w; i++) begin
      fp_word[block_w-1-i] = preoutput[block_w-1-fp_tab[i]];
    end
  end

  assign last_round = busy && round_cnt == round_w'(num_rounds - 1);

  always_ff @(posedge CLK) begin
    if (start) begin
      state_q.word <= ip_word;
    end else if (busy) begin
      state_q <= round_out;
    end
    if (last_round) result.word <= fp_word;
  end

  always_ff @(posedge CLK or negedge RST) begin
    if (!RST) begin
      busy      <= 1'b0;
      round_cnt <= '0;
      done      <= 1'b0;
    end else begin
      done <= last_round;
      if (start) begin
        busy      <= 1'b1;
        round_cnt <= '0;
      end else if (busy) begin
        round_cnt <= round_cnt + round_w'(1);
        if (last_round) busy <= 1'b0;
      end
    end
  end

  // one block in flight, the stream unit waits for done
  a_no_restart: assert property (@(posedge CLK) disable iff (!RST) start |-> !busy);

endmodule

`default_nettype wire

/* src/des_key_schedule.sv */
`default_nettype none

module des_key_schedule (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         start,
  input  logic                         step,
  input  logic [des_pkg::key_w-1:0]    key,
  output logic [des_pkg::subkey_w-1:0] subkey
);

  import des_pkg::*;

  logic [2*cd_w-1:0]  pc1_word;
  logic [cd_w-1:0]    c_q, d_q;
  logic [cd_w-1:0]    c_rot, d_rot;
  logic [2*cd_w-1:0]  cd_rot;
  logic [round_w-1:0] round_cnt; // steps taken since start
  logic               double_shift;

  always_comb begin
    for (int i = 0; i < 2*cd_w; i++) begin
      pc1_word[2*cd_w-1-i] = key[key_w-1-pc1_tab[i]];
    end
  end

  // rotation for the current round sits in front of pc2, so no extra cycle
  assign double_shift = shift_tab[round_cnt[round_w-2:0]] == 2'd2;
  assign c_rot = double_shift ? {c_q[cd_w-3:0], c_q[cd_w-1 -: 2]} : {c_q[cd_w-2:0], c_q[cd_w-1]};
  assign d_rot = double_shift ? {d_q[cd_w-3:0], d_q[cd_w-1 -: 2]} : {d_q[cd_w-2:0], d_q[cd_w-1]};
  assign cd_rot = {c_rot, d_rot};

  always_comb begin
    for (int i = 0; i < subkey_w; i++) begin
      subkey[subkey_w-1-i] = cd_rot[2*cd_w-1-pc2_tab[i]];
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      c_q <= pc1_word[2*cd_w-1 -: cd_w];
      d_q <= pc1_word[cd_w-1:0];
    end else if (step) begin
      c_q <= c_rot;
      d_q <= d_rot;
    end
  end

  always_ff @(posedge CLK or negedge RST) begin
    if (!RST) begin
      round_cnt <= '0;
    end else if (start) begin
      round_cnt <= '0;
    end else if (step) begin
      round_cnt <= round_cnt + round_w'(1);
    end
  end

  // the cipher must restart before asking for a seventeenth key
  a_step_in_range: assert property (@(posedge CLK) disable iff (!RST)
    step |-> round_cnt < round_w'(num_rounds));

endmodule

`default_nettype wire

/* src/des_round.sv */
`default_nettype none

module des_round (
  input  des_pkg::des_block_u          half_in,
  input  logic [des_pkg::subkey_w-1:0] subkey,
  output des_pkg::des_block_u          half_out
);

  import des_pkg::*;

  logic [subkey_w-1:0] expanded;
  logic [subkey_w-1:0] mixed;
  logic [half_w-1:0]   substituted;
  logic [half_w-1:0]   f_out;
  logic [5:0]          group;

  always_comb begin
    for (int i = 0; i < subkey_w; i++) begin
      expanded[subkey_w-1-i] = half_in.halves.right[half_w-1-e_tab[i]];
    end
  end

  assign mixed = expanded ^ subkey;

  // eight six-bit groups, outer bits pick the row
  always_comb begin
    group = '0;
    for (int s = 0; s < 8; s++) begin
      group = mixed[subkey_w-1-6*s -: 6];
      substituted[half_w-1-4*s -: 4] = sbox_tab[s][{group[5], group[0], group[4:1]}];
    end
  end

  always_comb begin
    for (int i = 0; i < half_w; i++) begin
      f_out[half_w-1-i] = substituted[half_w-1-p_tab[i]];
    end
  end

  assign half_out.word = {half_in.halves.right, half_in.halves.left ^ f_out}; // swap

endmodule

`default_nettype wire

/* src/des_pkg.sv */
`default_nettype none

package des_pkg;

  localparam int block_w    = 64;
  localparam int half_w     = 32;
  localparam int subkey_w   = 48;
  localparam int key_w      = 64;
  localparam int cd_w       = 28; // C and D key halves
  localparam int num_rounds = 16;
  localparam int round_w    = 5;
  localparam int byte_w     = 8;

  localparam int out_credits = 4;
  localparam int credit_w    = 3;

  // all permutation entries are 0-based, counted from the msb as in the DES standard
  localparam logic [5:0] ip_tab [64] = '{
    57, 49, 41, 33, 25, 17,  9,  1,
    59, 51, 43, 35, 27, 19, 11,  3,
    61, 53, 45, 37, 29, 21, 13,  5,
    63, 55, 47, 39, 31, 23, 15,  7,
    56, 48, 40, 32, 24, 16,  8,  0,
    58, 50, 42, 34, 26, 18, 10,  2,
    60, 52, 44, 36, 28, 20, 12,  4,
    62, 54, 46, 38, 30, 22, 14,  6
  };

  localparam logic [5:0] fp_tab [64] = '{
    39,  7, 47, 15, 55, 23, 63, 31,
    38,  6, 46, 14, 54, 22, 62, 30,
    37,  5, 45, 13, 53, 21, 61, 29,
    36,  4, 44, 12, 52, 20, 60, 28,
    35,  3, 43, 11, 51, 19, 59, 27,
    34,  2, 42, 10, 50, 18, 58, 26,
    33,  1, 41,  9, 49, 17, 57, 25,
    32,  0, 40,  8, 48, 16, 56, 24
  };

  localparam logic [5:0] e_tab [48] = '{
    31,  0,  1,  2,  3,  4,
     3,  4,  5,  6,  7,  8,
     7,  8,  9, 10, 11, 12,
    11, 12, 13, 14, 15, 16,
    15, 16, 17, 18, 19, 20,
    19, 20, 21, 22, 23, 24,
    23, 24, 25, 26, 27, 28,
    27, 28, 29, 30, 31,  0
  };

  localparam logic [5:0] p_tab [32] = '{
    15,  6, 19, 20, 28, 11, 27, 16,
     0, 14, 22, 25,  4, 17, 30,  9,
     1,  7, 23, 13, 31, 26,  2,  8,
    18, 12, 29,  5, 21, 10,  3, 24
  };

  localparam logic [5:0] pc1_tab [56] = '{
    56, 48, 40, 32, 24, 16,  8,
     0, 57, 49, 41, 33, 25, 17,
     9,  1, 58, 50, 42, 34, 26,
    18, 10,  2, 59, 51, 43, 35,
    62, 54, 46, 38, 30, 22, 14,
     6, 61, 53, 45, 37, 29, 21,
    13,  5, 60, 52, 44, 36, 28,
    20, 12,  4, 27, 19, 11,  3
  };

  localparam logic [5:0] pc2_tab [48] = '{
    13, 16, 10, 23,  0,  4,
     2, 27, 14,  5, 20,  9,
    22, 18, 11,  3, 25,  7,
    15,  6, 26, 19, 12,  1,
    40, 51, 30, 36, 46, 54,
    29, 39, 50, 44, 32, 47,
    43, 48, 38, 55, 33, 52,
    45, 41, 49, 35, 28, 31
  };

  localparam logic [1:0] shift_tab [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

  // row-major, index is {outer bits, inner bits} of the six-bit group
  localparam logic [3:0] sbox_tab [8][64] = '{
    '{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
       0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
       4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
      15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13},
    '{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
       3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
       0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
      13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9},
    '{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
      13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
      13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
       1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12},
    '{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
      13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
      10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
       3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14},
    '{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
      14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
       4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
      11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3},
    '{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
      10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
       9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
       4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13},
    '{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
      13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
       1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
       6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12},
    '{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
       1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
       7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
       2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}
  };

  typedef struct packed {
    logic [half_w-1:0] left;
    logic [half_w-1:0] right;
  } des_halves_t;

  // word view at the permutations, halves view inside the rounds
  typedef union packed {
    logic [block_w-1:0] word;
    des_halves_t        halves;
  } des_block_u;

  typedef struct packed {
    logic [key_w-1:0]   key;
    logic [block_w-1:0] iv;
  } ofb_cfg_t;

  typedef struct packed {
    logic              valid;
    logic [byte_w-1:0] data;
  } byte_beat_t;

endpackage

`default_nettype wire
